// File: logic/memory_pkg.sv
/*
 * Instruction-memory request and answer formats shared by fetch and testbench.
 * Memory must answer in request order; no tags are carried.
 * Only word-sized instruction reads are issued by the fetch side.
 */

`default_nettype none

package memory_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned XLEN = 32;

    // --------------------------------------------------
    // Exception causes seen by fetch
    // --------------------------------------------------
    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED = 4'h0,
        E_I_ACCESS_FAULT    = 4'h1
    } except_code_t;

    // Kind of memory access
    typedef enum logic [1:0] {
        MEM_ACC_INSTR = 2'h0,
        MEM_ACC_LD    = 2'h1,
        MEM_ACC_ST    = 2'h2
    } mem_acc_t;

    // Access size for loads and stores
    typedef enum logic [1:0] {
        LS_BYTE = 2'h0,
        LS_HALF = 2'h1,
        LS_WORD = 2'h2
    } ls_type_t;

    // --------------------------------------------------
    // Request and answer
    // --------------------------------------------------
    typedef struct packed {
        mem_acc_t          acc_type;
        ls_type_t          ls_type;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   value;    // Store data, zero on reads
    } mem_req_t;

    typedef struct packed {
        mem_acc_t          acc_type;
        logic [XLEN-1:0]   addr;     // Echo of the request address
        logic [XLEN-1:0]   value;
        logic              except_raised;
        except_code_t      except_code;
    } mem_ans_t;

endpackage

`default_nettype wire

// File: logic/fetch_pkg.sv
/*
 * Fetch-side types and sizes.
 * Instruction buffer depth is fixed here; pointer and counter widths
 * are derived from it, and the pointer wrap handles non power of two depths.
 */

`default_nettype none

package fetch_pkg;

    // --------------------------------------------------
    // Widths and PC stepping
    // --------------------------------------------------
    localparam int unsigned ILEN = 32;

    // Sequential fetch, no compressed instructions
    localparam logic [memory_pkg::XLEN-1:0] PC_STEP = 'd4;

    // --------------------------------------------------
    // Instruction and answer register payload
    // --------------------------------------------------
    typedef struct packed {
        logic [ILEN-1:0] raw;
    } instr_t;

    // Also used as the instruction buffer entry
    typedef struct packed {
        instr_t                          instr;
        logic [memory_pkg::XLEN-1:0]     addr;
        logic                            except_raised;
        memory_pkg::except_code_t        except_code;
    } mem_if_ans_reg_t;

    // --------------------------------------------------
    // Instruction buffer sizing
    // --------------------------------------------------
    localparam int unsigned INSTR_BUF_DEPTH = 4;
    localparam int unsigned INSTR_BUF_PTR_W = (INSTR_BUF_DEPTH > 1) ? $clog2(INSTR_BUF_DEPTH) : 1;
    localparam int unsigned INSTR_BUF_CNT_W = $clog2(INSTR_BUF_DEPTH + 1);

    typedef logic [INSTR_BUF_PTR_W-1:0] buf_ptr_t;
    typedef logic [INSTR_BUF_CNT_W-1:0] buf_cnt_t;

    // Last slot index and full level
    localparam buf_ptr_t INSTR_BUF_LAST = buf_ptr_t'(INSTR_BUF_DEPTH - 1);
    localparam buf_cnt_t INSTR_BUF_FULL = buf_cnt_t'(INSTR_BUF_DEPTH);

endpackage

`default_nettype wire

// File: logic/spill_cell.sv
/*
 * One-entry registered valid/ready stage, payload given by DATA_T.
 * Output is always registered; ready_o depends combinationally on ready_i,
 * so a chain of cells runs at full rate but forms a ready path.
 * Payload register has no reset, only the full flag does.
 */

`default_nettype none

module spill_cell #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  reset_i,

    // Upstream side
    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,

    // Downstream side
    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    // --------------------------------------------------
    // Internal state
    // --------------------------------------------------
    logic  full_q;
    DATA_T data_q;
    logic  load;
    logic  drain;

    // Free slot, or slot emptied this cycle
    assign ready_o = ~full_q | ready_i;

    assign load    = valid_i & ready_o;
    assign drain   = full_q & ready_i;

    // --------------------------------------------------
    // Full flag
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // Payload, overwritten only on accept
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign valid_o = full_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// File: logic/fetch_pc_gen.sv
/*
 * Sequential PC source for the fetch front end.
 * Boot PC is sampled on every reset cycle, the last one wins.
 * Low two bits are forced to zero; no redirection or flush support.
 */

`default_nettype none

module fetch_pc_gen (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [memory_pkg::XLEN-1:0] boot_pc_i,

    // Toward the memory interface
    output logic                        pc_valid_o,
    input  logic                        pc_ready_i,
    output logic [memory_pkg::XLEN-1:0] pc_o
);

    // --------------------------------------------------
    // Next PC state
    // --------------------------------------------------
    logic [memory_pkg::XLEN-1:0] pc_q;
    logic                        valid_q;
    logic                        advance;

    // PC handed over this cycle
    assign advance = valid_q & pc_ready_i;

    // Boot address loaded while in reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= boot_pc_i;
        end else if (advance) begin
            pc_q <= pc_q + fetch_pkg::PC_STEP;
        end
    end

    // Valid rises on the first edge after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign pc_valid_o = valid_q;

    // Word alignment
    assign pc_o = {pc_q[memory_pkg::XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

// File: logic/fetch_mem_if.sv
/*
 * Memory interface of the fetch front end.
 * One registered request slot and one registered answer slot.
 * Answers must come back in order; non-instruction answers are
 * acknowledged and dropped, never forwarded.
 */

`default_nettype none

module fetch_mem_if (
    input  logic                        clk_i,
    input  logic                        reset_i,

    // PC generator
    input  logic                        fetch_valid_i,
    output logic                        fetch_ready_o,
    input  logic [memory_pkg::XLEN-1:0] fetch_pc_i,

    // Memory request
    output logic                        mem_valid_o,
    input  logic                        mem_ready_i,
    output memory_pkg::mem_req_t        mem_req_o,

    // Memory answer
    input  logic                        mem_valid_i,
    output logic                        mem_ready_o,
    input  memory_pkg::mem_ans_t        mem_ans_i,

    // Instruction buffer
    output logic                        ans_valid_o,
    input  logic                        ans_ready_i,
    output fetch_pkg::mem_if_ans_reg_t  ans_o
);

    // --------------------------------------------------
    // Internal signals
    // --------------------------------------------------
    logic [memory_pkg::XLEN-1:0] req_pc;
    logic                        ans_is_instr;
    logic                        ans_valid;
    fetch_pkg::mem_if_ans_reg_t  ans_d;

    // Request slot, holds the PC until memory takes it
    spill_cell #(
        .DATA_T (logic [memory_pkg::XLEN-1:0])
    ) u_req_cell (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (fetch_valid_i),
        .ready_o (fetch_ready_o),
        .data_i  (fetch_pc_i),
        .valid_o (mem_valid_o),
        .ready_i (mem_ready_i),
        .data_o  (req_pc)
    );

    // Word instruction read
    assign mem_req_o.acc_type = memory_pkg::MEM_ACC_INSTR;
    assign mem_req_o.ls_type  = memory_pkg::LS_WORD;
    assign mem_req_o.addr     = req_pc;
    assign mem_req_o.value    = '0;

    // --------------------------------------------------
    // Answer filtering and repacking
    // --------------------------------------------------
    assign ans_is_instr = (mem_ans_i.acc_type == memory_pkg::MEM_ACC_INSTR);

    // Loads and stores never enter the slot
    assign ans_valid = mem_valid_i & ans_is_instr;

    assign ans_d.instr.raw     = mem_ans_i.value[fetch_pkg::ILEN-1:0];
    assign ans_d.addr          = mem_ans_i.addr;
    assign ans_d.except_raised = mem_ans_i.except_raised;
    assign ans_d.except_code   = mem_ans_i.except_code;

    // Its ready also acknowledges dropped answers
    spill_cell #(
        .DATA_T (fetch_pkg::mem_if_ans_reg_t)
    ) u_ans_cell (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (ans_valid),
        .ready_o (mem_ready_o),
        .data_i  (ans_d),
        .valid_o (ans_valid_o),
        .ready_i (ans_ready_i),
        .data_o  (ans_o)
    );

endmodule

`default_nettype wire

// File: logic/fetch_instr_buf.sv
/*
 * Circular FIFO of fetched instructions toward decode.
 * Depth set in fetch_pkg. No bypass, so an entry shows up at decode
 * one cycle after it is written. Storage has no reset.
 */

`default_nettype none

module fetch_instr_buf (
    input  logic                        clk_i,
    input  logic                        reset_i,

    // From the memory interface
    input  logic                        ans_valid_i,
    output logic                        ans_ready_o,
    input  fetch_pkg::mem_if_ans_reg_t  ans_i,

    // Decode stage
    output logic                        dec_valid_o,
    input  logic                        dec_ready_i,
    output fetch_pkg::instr_t           dec_instr_o,
    output logic [memory_pkg::XLEN-1:0] dec_pc_o,
    output logic                        dec_except_raised_o,
    output memory_pkg::except_code_t    dec_except_code_o
);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    fetch_pkg::mem_if_ans_reg_t buf_q [fetch_pkg::INSTR_BUF_DEPTH];
    fetch_pkg::buf_ptr_t        wr_ptr_q;
    fetch_pkg::buf_ptr_t        rd_ptr_q;
    fetch_pkg::buf_cnt_t        cnt_q;
    logic                       push;
    logic                       pop;
    fetch_pkg::mem_if_ans_reg_t head;

    assign ans_ready_o = (cnt_q != fetch_pkg::INSTR_BUF_FULL);
    assign dec_valid_o = (cnt_q != '0);

    assign push = ans_valid_i & ans_ready_o;
    assign pop  = dec_valid_o & dec_ready_i;

    // Write side
    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= ans_i;
        end
    end

    // Pointers wrap at the last slot
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == fetch_pkg::INSTR_BUF_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == fetch_pkg::INSTR_BUF_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else begin
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // --------------------------------------------------
    // Head entry onto decode fields
    // --------------------------------------------------
    assign head                = buf_q[rd_ptr_q];
    assign dec_instr_o         = head.instr;
    assign dec_pc_o            = head.addr;
    assign dec_except_raised_o = head.except_raised;
    assign dec_except_code_o   = head.except_code;

endmodule

`default_nettype wire

// File: logic/fetch_frontend.sv
/*
 * Instruction fetch front end, top level.
 * Instruction memory is external and must answer in order.
 * Answer to decode takes at least two cycles; no redirection or flush.
 */

`default_nettype none

module fetch_frontend (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [memory_pkg::XLEN-1:0] boot_pc_i,

    // Instruction memory request
    output logic                        mem_valid_o,
    input  logic                        mem_ready_i,
    output memory_pkg::mem_req_t        mem_req_o,

    // Instruction memory answer
    input  logic                        mem_valid_i,
    output logic                        mem_ready_o,
    input  memory_pkg::mem_ans_t        mem_ans_i,

    // Decode stage
    output logic                        dec_valid_o,
    input  logic                        dec_ready_i,
    output fetch_pkg::instr_t           dec_instr_o,
    output logic [memory_pkg::XLEN-1:0] dec_pc_o,
    output logic                        dec_except_raised_o,
    output memory_pkg::except_code_t    dec_except_code_o
);

    // --------------------------------------------------
    // Inter-stage links
    // --------------------------------------------------
    logic                        pc_valid;
    logic                        pc_ready;
    logic [memory_pkg::XLEN-1:0] pc;
    logic                        ans_valid;
    logic                        ans_ready;
    fetch_pkg::mem_if_ans_reg_t  ans;

    // PC source
    fetch_pc_gen u_pc_gen (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .boot_pc_i  (boot_pc_i),
        .pc_valid_o (pc_valid),
        .pc_ready_i (pc_ready),
        .pc_o       (pc)
    );

    // Request and answer registers
    fetch_mem_if u_mem_if (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_valid_i (pc_valid),
        .fetch_ready_o (pc_ready),
        .fetch_pc_i    (pc),
        .mem_valid_o   (mem_valid_o),
        .mem_ready_i   (mem_ready_i),
        .mem_req_o     (mem_req_o),
        .mem_valid_i   (mem_valid_i),
        .mem_ready_o   (mem_ready_o),
        .mem_ans_i     (mem_ans_i),
        .ans_valid_o   (ans_valid),
        .ans_ready_i   (ans_ready),
        .ans_o         (ans)
    );

    // Buffer toward decode
    fetch_instr_buf u_instr_buf (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .ans_valid_i         (ans_valid),
        .ans_ready_o         (ans_ready),
        .ans_i               (ans),
        .dec_valid_o         (dec_valid_o),
        .dec_ready_i         (dec_ready_i),
        .dec_instr_o         (dec_instr_o),
        .dec_pc_o            (dec_pc_o),
        .dec_except_raised_o (dec_except_raised_o),
        .dec_except_code_o   (dec_except_code_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_fetch_frontend.sv
/*
 * Testbench for the fetch front end, with a random-latency in-order memory model.
 * Memory may inject load answers, which must never reach decode.
 * Inputs change on rising edges only; the run is bounded by a cycle limit.
 */

`default_nettype none

module tb_fetch_frontend;

    timeunit 1ns;
    timeprecision 100ps;

    // --------------------------------------------------
    // Run parameters
    // --------------------------------------------------
    localparam logic [31:0] BOOT_PC        = 32'h0000_1000;
    localparam int          N_FETCH        = 200;
    localparam int          STALL_AT       = 100;
    localparam int          STALL_CYCLES   = 30;
    localparam int          MAX_DELAY      = 5;
    // Fetches 150 and up hit the faulting region
    localparam logic [31:0] FAULT_ADDR     = BOOT_PC + 32'd600;
    localparam int          TIMEOUT_CYCLES = 10 * N_FETCH * MAX_DELAY;

    logic                        clk_i;
    logic                        reset_i;
    logic [31:0]                 boot_pc_i;
    logic                        mem_valid_o;
    logic                        mem_ready_i;
    memory_pkg::mem_req_t        mem_req_o;
    logic                        mem_valid_i;
    logic                        mem_ready_o;
    memory_pkg::mem_ans_t        mem_ans_i;
    logic                        dec_valid_o;
    logic                        dec_ready_i;
    fetch_pkg::instr_t           dec_instr_o;
    logic [31:0]                 dec_pc_o;
    logic                        dec_except_raised_o;
    memory_pkg::except_code_t    dec_except_code_o;

    // Model state
    integer      seed = 32584;
    logic [31:0] req_q [$];
    logic [31:0] ref_q [$];
    logic [31:0] exp_pc = BOOT_PC;
    logic [31:0] exp_req_pc = BOOT_PC;
    logic [31:0] prev_pc;
    logic [31:0] prev_instr;
    logic        prev_valid = 1'b0;
    logic        prev_taken = 1'b0;
    logic        ans_busy = 1'b0;
    logic        ans_real = 1'b0;
    int          ans_wait = 0;
    int          n_fetched = 0;
    int          n_faults = 0;
    int          n_injected = 0;
    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    logic        stall_req = 1'b0;
    logic        stall_started = 1'b0;
    int          stall_left = 0;
    logic        saw_mem_stall = 1'b0;
    string       cur_test = "reset_idle";

    fetch_frontend UUT (.*);

    always #4 clk_i = ~clk_i;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s expected %h actual %h", cur_test, name, exp, act);
        end
    endtask

    task automatic report_test(input int errs_before);
        if (errors == errs_before) begin
            n_pass++;
            $display("Test %s passed", cur_test);
        end else begin
            n_fail++;
            $display("Test %s failed with %0d errors", cur_test, errors - errs_before);
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // Instruction word stored at an address
    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        addr_hash = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
    endfunction

    function automatic memory_pkg::mem_ans_t instr_answer(input logic [31:0] addr);
        memory_pkg::mem_ans_t ans;
        ans.acc_type      = memory_pkg::MEM_ACC_INSTR;
        ans.addr          = addr;
        ans.value         = addr_hash(addr);
        ans.except_raised = (addr >= FAULT_ADDR);
        ans.except_code   = ans.except_raised ? memory_pkg::E_I_ACCESS_FAULT
                                              : memory_pkg::E_I_ADDR_MISALIGNED;
        return ans;
    endfunction

    // Stray load answer, far from the fetch range
    function automatic memory_pkg::mem_ans_t load_answer(input logic [31:0] rnd);
        memory_pkg::mem_ans_t ans;
        ans.acc_type      = memory_pkg::MEM_ACC_LD;
        ans.addr          = 32'hF000_0000 | {16'h0, rnd[15:2], 2'b00};
        ans.value         = rnd;
        ans.except_raised = 1'b0;
        ans.except_code   = memory_pkg::E_I_ADDR_MISALIGNED;
        return ans;
    endfunction

    // --------------------------------------------------
    // Memory model, decode sink and output checks
    // --------------------------------------------------
    always @(posedge clk_i) begin : model
        logic [31:0] ref_pc;
        if (reset_i) begin
            mem_valid_i <= 1'b0;
            mem_ready_i <= 1'b0;
            dec_ready_i <= 1'b0;
        end else begin
            // Held output must not change
            if (prev_valid && !prev_taken) begin
                check("hold_valid", 1, dec_valid_o);
                check("hold_pc", prev_pc, dec_pc_o);
                check("hold_instr", prev_instr, dec_instr_o.raw);
            end
            // Request accepted by memory
            if (mem_valid_o && mem_ready_i) begin
                check("req_addr", exp_req_pc, mem_req_o.addr);
                check("req_acc", memory_pkg::MEM_ACC_INSTR, mem_req_o.acc_type);
                check("req_size", memory_pkg::LS_WORD, mem_req_o.ls_type);
                check("req_value", 0, mem_req_o.value);
                req_q.push_back(mem_req_o.addr);
                exp_req_pc += 4;
            end
            // Answer taken by the DUT
            if (ans_busy && mem_ready_o) begin
                if (ans_real) begin
                    ref_q.push_back(req_q.pop_front());
                    ans_wait = rand_below(MAX_DELAY + 1);
                end else begin
                    n_injected++;
                end
                ans_busy = 1'b0;
                mem_valid_i <= 1'b0;
            end
            // Next answer, injected load or oldest request
            if (!ans_busy) begin
                if (ans_wait > 0) begin
                    ans_wait--;
                end
                if (stall_left == 0 && rand_below(6) == 0) begin
                    mem_ans_i   <= load_answer($random(seed));
                    mem_valid_i <= 1'b1;
                    ans_busy = 1'b1;
                    ans_real = 1'b0;
                end else if (ans_wait == 0 && req_q.size() > 0) begin
                    mem_ans_i   <= instr_answer(req_q[0]);
                    mem_valid_i <= 1'b1;
                    ans_busy = 1'b1;
                    ans_real = 1'b1;
                end
            end
            mem_ready_i <= (rand_below(4) != 0);

            // Instruction taken by decode
            if (dec_valid_o && dec_ready_i) begin
                if (ref_q.size() == 0) begin
                    errors++;
                    $display("Decode got PC %h that memory never answered", dec_pc_o);
                end else begin
                    ref_pc = ref_q.pop_front();
                    check("pc_ref", ref_pc, dec_pc_o);
                end
                check("pc_seq", exp_pc, dec_pc_o);
                check("instr", addr_hash(exp_pc), dec_instr_o.raw);
                check("except_raised", exp_pc >= FAULT_ADDR, dec_except_raised_o);
                if (exp_pc >= FAULT_ADDR) begin
                    check("except_code", memory_pkg::E_I_ACCESS_FAULT, dec_except_code_o);
                end
                // Faults as reported by the DUT
                if (dec_except_raised_o) begin
                    n_faults++;
                end
                exp_pc += 4;
                n_fetched++;
            end
            prev_valid = dec_valid_o;
            prev_taken = dec_valid_o && dec_ready_i;
            prev_pc    = dec_pc_o;
            prev_instr = dec_instr_o.raw;

            // Decode stall window
            if (stall_left > 0 && !mem_ready_o) begin
                saw_mem_stall = 1'b1;
            end
            if (stall_req && !stall_started) begin
                stall_started = 1'b1;
                stall_left    = STALL_CYCLES;
            end
            if (stall_left > 0) begin
                dec_ready_i <= 1'b0;
                stall_left--;
            end else begin
                dec_ready_i <= (rand_below(4) != 0);
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions decoded",
                     cycles, n_fetched, N_FETCH);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : sequence_ctrl
        int errs_before;
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        boot_pc_i   = BOOT_PC;
        mem_valid_i = 1'b0;
        mem_ready_i = 1'b0;
        mem_ans_i   = '0;
        dec_ready_i = 1'b0;

        // Valids stay low through reset and the first cycle after it
        errs_before = errors;
        repeat (15) begin
            @(negedge clk_i);
            check("dec_valid", 0, dec_valid_o);
            check("mem_valid", 0, mem_valid_o);
        end
        @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check("dec_valid", 0, dec_valid_o);
        check("mem_valid", 0, mem_valid_o);
        check("mem_ready", 1, mem_ready_o);
        report_test(errs_before);

        // Random stream with load injection
        cur_test    = "stream";
        errs_before = errors;
        while (n_fetched < STALL_AT) begin
            @(negedge clk_i);
        end
        report_test(errs_before);

        // Decode held off, back-pressure must reach memory
        cur_test    = "decode_stall";
        errs_before = errors;
        stall_req   = 1'b1;
        @(negedge clk_i);
        while (stall_left > 0) begin
            @(negedge clk_i);
        end
        check("mem_ready_fell", 1, saw_mem_stall);
        report_test(errs_before);

        // Sequence resumes through the fault boundary
        cur_test    = "resume";
        errs_before = errors;
        while (n_fetched < N_FETCH) begin
            @(negedge clk_i);
        end
        check("fault_count", N_FETCH - 150, n_faults);
        check("ld_injected", 1, n_injected != 0);
        report_test(errs_before);

        $display("Tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_frontend.f
logic/memory_pkg.sv
logic/fetch_pkg.sv
logic/spill_cell.sv
logic/fetch_pc_gen.sv
logic/fetch_mem_if.sv
logic/fetch_instr_buf.sv
logic/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  # Packages first, then the RTL in dependency order
  - logic/memory_pkg.sv
  - logic/fetch_pkg.sv
  - logic/spill_cell.sv
  - logic/fetch_pc_gen.sv
  - logic/fetch_mem_if.sv
  - logic/fetch_instr_buf.sv
  - logic/fetch_frontend.sv

  # Testbench
  - target: simulation
    files:
      - tb/tb_fetch_frontend.sv
